// File: all.f
+incdir+verilog
verilog/ddr_req_pkg.sv
verilog/ddr_timing_pkg.sv
verilog/ddr_admit_ctrl.sv
verilog/ddr_req_queue.sv
verilog/ddr_latency_pipe.sv
verilog/ddr_mem_array.sv
verilog/ddr_sim_top.sv
tests/ddr_sim_tb.sv

// File: run.sh
#!/bin/sh
# Build the DDR3 model testbench with Verilator and run it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module ddr_sim_tb \
    -Mdir obj_dir \
    -o ddr_sim_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/ddr_sim_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished with status 0"
exit 0

// File: tests/ddr_sim_tb.sv
/* DDR3 model testbench */

`timescale 1ns/1ps
`include "ddr_sim_defs.svh"

module ddr_sim_tb;
    import ddr_req_pkg::*;

    localparam int NUM_REQ      = 600;
    localparam int IDLE_CYC     = 200;
    localparam int NUM_BANK     = 1 << `DDR_BAK;
    localparam int WATCHDOG_CYC = NUM_REQ * (`DDR_REFRESH_PERIOD + 64);

    logic                clk;
    logic                rst;
    logic                req;
    ddr_req_t            req_info;
    logic                ack;
    logic                rvl;
    logic [`DDR_WID-1:0] rdd;

    // Stimulus state
    logic [31:0]         rng_state;
    ddr_addr_t           wr_addr_list [$];

    // Reference model state
    logic [`DDR_WID-1:0] model_mem [2**`DDR_ADDR_W];
    logic [`DDR_WID-1:0] exp_q [$];
    int                  cyc;
    int                  reads_accepted;
    int                  rvl_count;
    int                  bank_last_cyc [NUM_BANK];
    logic [`DDR_ROW-1:0] bank_last_row [NUM_BANK];
    bit                  bank_seen [NUM_BANK];
    int                  grp_last_cyc [2];
    bit                  grp_seen [2];

    ddr_sim_top ddr_sim_top_inst
    (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_info (req_info),
        .ack      (ack),
        .rvl      (rvl),
        .rdd      (rdd)
    );

    ////////////////////////////////////////////////////////////
    // Reporting
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic compare_value(input string name, input logic [`DDR_WID-1:0] expected,
                                 input logic [`DDR_WID-1:0] actual);
        if (actual !== expected)
            report_failure($sformatf("mismatch %s expected 0x%h actual 0x%h",
                                     name, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////
    // Random stimulus
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    // Reads only target addresses that already hold an accepted write
    task automatic make_request(output ddr_req_t r);
        logic [31:0] a;
        logic [31:0] d_hi;
        logic [31:0] d_lo;
        int          idx;
        draw_random(a);
        draw_random(d_hi);
        draw_random(d_lo);
        r.wdata = {d_hi, d_lo};
        if ((wr_addr_list.size() != 0) && (a[2:0] < 3'd3))
        begin
            idx    = int'(d_lo[15:0]) % wr_addr_list.size();
            r.op   = op_read;
            r.addr = wr_addr_list[idx];
        end
        else
        begin
            r.op        = op_write;
            r.addr.bank = a[8 +: `DDR_BAK];
            r.addr.col  = a[12 +: `DDR_COL];
            // Half the writes share a few rows, so open-row hits happen
            r.addr.row  = a[16] ? `DDR_ROW'(a[25:24]) : a[24 +: `DDR_ROW];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    task automatic record_accept();
        int bank;
        int grp;
        int gap;
        bank = int'(req_info.addr.bank);
        grp  = int'(req_info.addr.bank[0]);
        if ((cyc % `DDR_REFRESH_PERIOD) < `DDR_REFRESH_WIN)
            report_failure($sformatf("request acknowledged inside refresh window at cycle %0d",
                                     cyc));
        // Timers only pause, so the bank gap is a lower bound
        if (bank_seen[bank] && (req_info.addr.row != bank_last_row[bank]))
        begin
            gap = cyc - bank_last_cyc[bank];
            if (gap < `DDR_SAME_BANK)
                report_failure($sformatf("bank %0d opened a new row %0d cycles after its last ack",
                                         bank, gap));
        end
        if (grp_seen[grp])
        begin
            gap = cyc - grp_last_cyc[grp];
            if (gap < `DDR_GROUP_GAP + 1)
                report_failure($sformatf("bank group %0d acknowledged twice within %0d cycles",
                                         grp, gap));
        end
        bank_seen[bank]     = 1'b1;
        bank_last_cyc[bank] = cyc;
        bank_last_row[bank] = req_info.addr.row;
        grp_seen[grp]       = 1'b1;
        grp_last_cyc[grp]   = cyc;
        if (req_info.op == op_write)
            model_mem[req_info.addr] = req_info.wdata;
        else
        begin
            exp_q.push_back(model_mem[req_info.addr]);
            reads_accepted = reads_accepted + 1;
        end
    endtask

    task automatic check_read_return();
        logic [`DDR_WID-1:0] expected;
        if (exp_q.size() == 0)
            report_failure($sformatf("unexpected read return at cycle %0d, no read outstanding",
                                     cyc));
        else
        begin
            expected = exp_q.pop_front();
            compare_value("read_data", expected, rdd);
        end
        rvl_count = rvl_count + 1;
    endtask

    // Sampled mid-cycle, where inputs and registered outputs are settled
    always @(negedge clk)
    begin
        if (rst)
        begin
            cyc            = 0;
            reads_accepted = 0;
            rvl_count      = 0;
            exp_q.delete();
            for (int b = 0; b < NUM_BANK; b++)
                bank_seen[b] = 1'b0;
            grp_seen[0] = 1'b0;
            grp_seen[1] = 1'b0;
        end
        else
        begin
            if (ack)
                record_accept();
            if (rvl)
                check_read_return();
            cyc = cyc + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Clock, reset, request driver
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        ddr_req_t nreq;
        rng_state = 32'hea0eb012;
        rst       = 1'b1;
        req       = 1'b0;
        req_info  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Each request is held until the model acknowledges it
        for (int n = 0; n < NUM_REQ; n++)
        begin
            make_request(nreq);
            req      = 1'b1;
            req_info = nreq;
            do
                @(negedge clk);
            while (!ack);
            if (nreq.op == op_write)
                wr_addr_list.push_back(nreq.addr);
            @(posedge clk);
            #1;
        end
        req      = 1'b0;
        req_info = '0;

        // Drain queue and pipeline
        repeat (IDLE_CYC) @(posedge clk);
        #1;
        $display("accepted reads %0d, read returns %0d", reads_accepted, rvl_count);
        if (rvl_count == reads_accepted)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
            compare_value("read_count", `DDR_WID'(reads_accepted), `DDR_WID'(rvl_count));
    end

    ////////////////////////////////////////////////////////////
    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        report_failure($sformatf("timeout after %0d cycles, the run did not finish",
                                 WATCHDOG_CYC));
    end

endmodule

// File: verilog/ddr_admit_ctrl.sv
/* DDR request admission control */

`timescale 1ns/1ps
`include "ddr_sim_defs.svh"

module ddr_admit_ctrl
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  ddr_req_pkg::ddr_req_t req_info,
    input  logic                  fifo_full,
    output logic                  ack
);
    import ddr_req_pkg::*;
    import ddr_timing_pkg::*;

    localparam int NUM_BANK = 1 << `DDR_BAK;
    localparam int BAK_W    = `DDR_BAK;
    localparam int RFSH_W   = $clog2(`DDR_REFRESH_PERIOD);
    localparam int GRP_W    = $clog2(`DDR_GROUP_GAP + 1);
    localparam logic [`DDR_BANK_TMR_W-1:0] SAME_BANK_LD = `DDR_SAME_BANK;

    logic [RFSH_W-1:0]   rfsh_cnt;
    rfsh_phase_t         rfsh_phase;
    bank_state_t         bank_st [NUM_BANK];
    logic [`DDR_BAK-1:0] last_bank;
    ddr_op_t             last_op;
    logic [1:0]          space_cnt;
    logic [GRP_W-1:0]    group_cnt [2];

    logic [`DDR_BAK-1:0] req_bank;
    logic                req_group;
    logic                bank_idle;
    logic                row_hit;
    logic                group_block;
    logic                timer_run;

    ////////////////////////////////////////////////////////////
    // Refresh period counter
    always_ff @(posedge clk)
    begin
        if (rst)
            rfsh_cnt <= '0;
        else if (rfsh_cnt == RFSH_W'(`DDR_REFRESH_PERIOD - 1))
            rfsh_cnt <= '0;
        else
            rfsh_cnt <= rfsh_cnt + 1'b1;
    end

    assign rfsh_phase = (rfsh_cnt < RFSH_W'(`DDR_REFRESH_WIN)) ? rfsh_window : rfsh_open;

    ////////////////////////////////////////////////////////////
    // Admission decision
    assign req_bank    = req_info.addr.bank;
    // Group is the low bank bit
    assign req_group   = req_bank[0];
    assign bank_idle   = (bank_st[req_bank].busy_cnt == '0);
    assign row_hit     = (bank_st[req_bank].open_row == req_info.addr.row);
    assign group_block = (group_cnt[req_group] != '0);

    assign ack = req && !fifo_full && (rfsh_phase == rfsh_open)
                 && (bank_idle || row_hit) && !group_block;

    ////////////////////////////////////////////////////////////
    // Command spacing on bank switch
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            last_bank <= '0;
            last_op   <= op_write;
            space_cnt <= '0;
        end
        else
        begin
            if (ack)
            begin
                last_bank <= req_bank;
                last_op   <= req_info.op;
            end
            // Read/write turnaround costs one more slot
            if (ack && (req_bank != last_bank))
                space_cnt <= (req_info.op != last_op) ? 2'd2 : 2'd1;
            else if (space_cnt != '0)
                space_cnt <= space_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bank group spacing with one counter per group
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            group_cnt[0] <= '0;
            group_cnt[1] <= '0;
        end
        else
        begin
            for (int g = 0; g < 2; g++)
            begin
                if (ack && (req_group == 1'(g)))
                    group_cnt[g] <= GRP_W'(`DDR_GROUP_GAP);
                else if (group_cnt[g] != '0)
                    group_cnt[g] <= group_cnt[g] - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Bank timers and open rows

    // Timers hold during refresh and while spacing is pending
    assign timer_run = (rfsh_phase == rfsh_open) && (space_cnt == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int b = 0; b < NUM_BANK; b++)
                bank_st[b] <= '0;
        end
        else
        begin
            for (int b = 0; b < NUM_BANK; b++)
            begin
                if (ack && (req_bank == BAK_W'(b)))
                begin
                    bank_st[b].busy_cnt <= SAME_BANK_LD;
                    bank_st[b].open_row <= req_info.addr.row;
                end
                else if (timer_run && (bank_st[b].busy_cnt != '0))
                    bank_st[b].busy_cnt <= bank_st[b].busy_cnt - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    // No back-to-back acks to one bank group
    a_group_gap: assert property (@(posedge clk) disable iff (rst)
        ack |=> !(ack && (req_group == $past(req_group))));

    // A bank just acked cannot switch rows in the next cycle
    a_row_busy: assert property (@(posedge clk) disable iff (rst)
        ack |=> !(ack && (req_bank == $past(req_bank))
                  && (req_info.addr.row != $past(req_info.addr.row))));

endmodule

// File: verilog/ddr_latency_pipe.sv
/* DDR access latency pipeline */

`timescale 1ns/1ps
`include "ddr_sim_defs.svh"

module ddr_latency_pipe
#(
    parameter int DEPTH = `DDR_LATENCY
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  ddr_req_pkg::ddr_req_t in_req,
    output logic                  acc_valid,
    output ddr_req_pkg::ddr_req_t acc_req
);
    import ddr_req_pkg::*;

    logic [DEPTH-1:0] vld_sr;
    ddr_req_t         req_sr [DEPTH];

    ////////////////////////////////////////////////////////////
    // Valid chain
    always_ff @(posedge clk)
    begin
        if (rst)
            vld_sr <= '0;
        else
        begin
            vld_sr[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++)
                vld_sr[i] <= vld_sr[i-1];
        end
    end

    // Request chain, moves alongside the valid bits
    always_ff @(posedge clk)
    begin
        req_sr[0] <= in_req;
        for (int i = 1; i < DEPTH; i++)
            req_sr[i] <= req_sr[i-1];
    end

    assign acc_valid = vld_sr[DEPTH-1];
    assign acc_req   = req_sr[DEPTH-1];

endmodule

// File: verilog/ddr_mem_array.sv
/* DDR memory array */

`timescale 1ns/1ps
`include "ddr_sim_defs.svh"

module ddr_mem_array
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  acc_valid,
    input  ddr_req_pkg::ddr_req_t acc_req,
    output logic                  rvl,
    output logic [`DDR_WID-1:0]   rdd
);
    import ddr_req_pkg::*;

    // One word per row, bank and column
    logic [`DDR_WID-1:0] mem [2**`DDR_ADDR_W];
    logic                wr_en;
    logic                rd_en;

    assign wr_en = acc_valid && (acc_req.op == op_write);
    assign rd_en = acc_valid && (acc_req.op == op_read);

    ////////////////////////////////////////////////////////////
    // Array write and registered read
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[acc_req.addr] <= acc_req.wdata;
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
            rdd <= mem[acc_req.addr];
    end

    // Read return strobe
    always_ff @(posedge clk)
    begin
        if (rst)
            rvl <= 1'b0;
        else
            rvl <= rd_en;
    end

endmodule

// File: verilog/ddr_req_pkg.sv
/* DDR request types */

`include "ddr_sim_defs.svh"

package ddr_req_pkg;

    ////////////////////////////////////////////////////////////
    // Operation code
    typedef enum logic
    {
        op_write = 1'b0,
        op_read  = 1'b1
    } ddr_op_t;

    ////////////////////////////////////////////////////////////
    // Address, flattened it is also the array index
    typedef struct packed
    {
        logic [`DDR_ROW-1:0] row;
        logic [`DDR_BAK-1:0] bank;
        logic [`DDR_COL-1:0] col;
    } ddr_addr_t;

    ////////////////////////////////////////////////////////////
    // Full request as carried through queue and pipeline
    typedef struct packed
    {
        ddr_op_t             op;
        ddr_addr_t           addr;
        // Ignored on reads
        logic [`DDR_WID-1:0] wdata;
    } ddr_req_t;

endpackage

// File: verilog/ddr_req_queue.sv
/* Paced request queue */

`timescale 1ns/1ps
`include "ddr_sim_defs.svh"

module ddr_req_queue
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  ddr_req_pkg::ddr_req_t push_req,
    output logic                  fifo_full,
    output logic                  issue_valid,
    output ddr_req_pkg::ddr_req_t issue_req
);
    import ddr_req_pkg::*;

    localparam int PTR_W  = $clog2(`DDR_FIFO_DEPTH);
    localparam int CNT_W  = $clog2(`DDR_FIFO_DEPTH + 1);
    localparam int PACE_W = $clog2(`DDR_PACE_PERIOD);

    ddr_req_t          entry_mem [`DDR_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fill;
    logic [PACE_W-1:0] pace_cnt;
    logic              pop;

    assign fifo_full = (fill == CNT_W'(`DDR_FIFO_DEPTH));
    // Issue only in the open slots of the pace period
    assign pop = (fill != '0) && (pace_cnt < PACE_W'(`DDR_PACE_ISSUE));

    ////////////////////////////////////////////////////////////
    // Pointers, fill count, pace counter
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            pace_cnt    <= '0;
            issue_valid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(`DDR_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`DDR_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                fill <= fill + 1'b1;
            else if (pop && !push)
                fill <= fill - 1'b1;
            pace_cnt    <= (pace_cnt == PACE_W'(`DDR_PACE_PERIOD - 1)) ? '0 : pace_cnt + 1'b1;
            issue_valid <= pop;
        end
    end

    // Storage and issue register
    always_ff @(posedge clk)
    begin
        if (push)
            entry_mem[wr_ptr] <= push_req;
        if (pop)
            issue_req <= entry_mem[rd_ptr];
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !fifo_full);

endmodule

// File: verilog/ddr_sim_defs.svh
/* DDR3 model constants */

`ifndef DDR_SIM_DEFS_SVH
`define DDR_SIM_DEFS_SVH

////////////////////////////////////////////////////////////
// Data and address widths
`define DDR_WID             64
`define DDR_ROW             8
`define DDR_BAK             3
`define DDR_COL             4
`define DDR_ADDR_W          (`DDR_ROW + `DDR_BAK + `DDR_COL)

////////////////////////////////////////////////////////////
// Access latency, issue to array
`define DDR_LATENCY         8

////////////////////////////////////////////////////////////
// Timing rules in clock cycles

// Bank busy time for a row change, timer width to hold it
`define DDR_SAME_BANK       21
`define DDR_BANK_TMR_W      5

// Refresh period and its blocked window at the start
`define DDR_REFRESH_PERIOD  1254
`define DDR_REFRESH_WIN     93

`define DDR_GROUP_GAP       2

// Issue pacing, 12 slots of every 16
`define DDR_PACE_PERIOD     16
`define DDR_PACE_ISSUE      12

`define DDR_FIFO_DEPTH      4

`endif

// File: verilog/ddr_sim_top.sv
/* DDR3 behavioral model top */

`timescale 1ns/1ps
`include "ddr_sim_defs.svh"

module ddr_sim_top
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  ddr_req_pkg::ddr_req_t req_info,
    output logic                  ack,
    output logic                  rvl,
    output logic [`DDR_WID-1:0]   rdd
);
    import ddr_req_pkg::*;

    logic     fifo_full;
    logic     issue_valid;
    ddr_req_t issue_req;
    logic     acc_valid;
    ddr_req_t acc_req;

    ////////////////////////////////////////////////////////////
    // Admission
    ddr_admit_ctrl ddr_admit_ctrl_inst
    (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_info  (req_info),
        .fifo_full (fifo_full),
        .ack       (ack)
    );

    ////////////////////////////////////////////////////////////
    // Queue, latency and array
    ddr_req_queue ddr_req_queue_inst
    (
        .clk         (clk),
        .rst         (rst),
        .push        (ack),
        .push_req    (req_info),
        .fifo_full   (fifo_full),
        .issue_valid (issue_valid),
        .issue_req   (issue_req)
    );

    ddr_latency_pipe #(.DEPTH(`DDR_LATENCY)) ddr_latency_pipe_inst
    (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (issue_valid),
        .in_req    (issue_req),
        .acc_valid (acc_valid),
        .acc_req   (acc_req)
    );

    ddr_mem_array ddr_mem_array_inst
    (
        .clk       (clk),
        .rst       (rst),
        .acc_valid (acc_valid),
        .acc_req   (acc_req),
        .rvl       (rvl),
        .rdd       (rdd)
    );

endmodule

// File: verilog/ddr_timing_pkg.sv
/* DDR timing state types */

`include "ddr_sim_defs.svh"

package ddr_timing_pkg;

    // Position inside the refresh period
    typedef enum logic
    {
        rfsh_window = 1'b0,
        rfsh_open   = 1'b1
    } rfsh_phase_t;

    ////////////////////////////////////////////////////////////
    // Per bank state
    typedef struct packed
    {
        logic [`DDR_ROW-1:0]        open_row;
        // Zero means bank idle, any row may be opened
        logic [`DDR_BANK_TMR_W-1:0] busy_cnt;
    } bank_state_t;

endpackage
